//--- include/fetch_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build constants for the fetch front end
// BTB_ENTRIES must equal 2**BTB_IDX_W
// IMEM_WORDS must equal 2**IMEM_AW
// IMEM_WAIT must be 1 or more
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// First fetch address out of reset
`define RESET_PC 32'h00000100

// Branch target buffer geometry
`define BTB_ENTRIES 16
`define BTB_IDX_W 4

// Instruction memory depth, in 32-bit words
`define IMEM_WORDS 256
`define IMEM_AW 8

// Busy cycles per memory read
`define IMEM_WAIT 2

// Bus delivers little-endian words, fetch swaps them
`define BUS_LITTLE_ENDIAN 1

`endif

//--- verilog/rv32_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I data types shared by the fetch path
// Only the major opcode field is encoded here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "fetch_consts.svh"

package rv32_types_pkg;

    typedef logic [31:0] word_t;

    // Word index into instruction memory
    typedef logic [`IMEM_AW-1:0] imem_idx_t;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        IMM    = 7'b0010011,
        REG    = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_t;

endpackage

`default_nettype wire

//--- verilog/fetch_ctrl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control encodings for the fetch front end
// npc_src_t is listed in priority order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fetch_ctrl_pkg;

    // Instruction memory read sequence
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DONE
    } imem_state_t;

    // Source of the next PC
    typedef enum logic [1:0] {
        REDIRECT,
        PREDICT,
        SEQ
    } npc_src_t;

endpackage

`default_nettype wire

//--- verilog/imem_bus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction memory with fixed wait states
// addr and load_addr are byte addresses, bits 1:0
// ignored, upper bits beyond IMEM_AW wrap
// Read address is captured when ren is accepted
// Contents are undefined until preloaded
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "fetch_consts.svh"

module imem_bus
    import rv32_types_pkg::*, fetch_ctrl_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    input  logic  ren,
    input  word_t addr,
    input  logic  load_en,
    input  word_t load_addr,
    input  word_t load_data,
    output logic  busy,
    output word_t rdata
);
    localparam int CNT_W = $clog2(`IMEM_WAIT + 1);

    word_t            mem [`IMEM_WORDS];
    imem_state_t      state;
    logic [CNT_W-1:0] wait_cnt;
    logic             last_wait;
    imem_idx_t        rd_idx;
    word_t            rd_word;

    assign last_wait = (state == WAIT) && (wait_cnt == CNT_W'(1));

    // Preload port, open in every state
    always_ff @(posedge CLK) begin
        if (load_en) begin
            mem[load_addr[`IMEM_AW+1:2]] <= load_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && ren) begin
            rd_idx <= addr[`IMEM_AW+1:2];
        end
        if (last_wait) begin
            rd_word <= mem[rd_idx];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (ren) begin
                        state    <= WAIT;
                        wait_cnt <= CNT_W'(`IMEM_WAIT);
                    end
                end
                WAIT: begin
                    if (last_wait) begin
                        state <= DONE;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                // Data shown for one cycle, then ready for the next request
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign busy  = (state == WAIT);
    assign rdata = rd_word;

    // Requester keeps ren up through the wait and the data cycle
    a_ren_held: assert property (@(posedge CLK) disable iff (!nRST)
        busy |-> ren ##1 ren)
        else $error("ren dropped during a memory read");

endmodule

`default_nettype wire

//--- verilog/branch_predictor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped branch target buffer
// Index is pc bits BTB_IDX_W+1:2, tag is the rest
// Any hit predicts taken, no direction counters
// Update is visible to lookup after the next edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "fetch_consts.svh"

module branch_predictor
    import rv32_types_pkg::*;
(
    input  logic    CLK,
    input  logic    nRST,
    input  word_t   current_pc,
    output logic    predict_taken,
    output word_t   target_addr,
    input  logic    bp_update,
    input  word_t   bp_pc,
    input  word_t   bp_target,
    input  opcode_t bp_opcode
);
    localparam int TAG_W = 30 - `BTB_IDX_W;

    logic [`BTB_ENTRIES-1:0] valid_tab;
    logic [TAG_W-1:0]        tag_tab [`BTB_ENTRIES];
    word_t                   tgt_tab [`BTB_ENTRIES];

    logic [`BTB_IDX_W-1:0] look_idx;
    logic [TAG_W-1:0]      look_tag;
    logic [`BTB_IDX_W-1:0] upd_idx;
    logic [TAG_W-1:0]      upd_tag;
    logic                  upd_en;

    assign look_idx = current_pc[`BTB_IDX_W+1:2];
    assign look_tag = current_pc[31:`BTB_IDX_W+2];
    assign upd_idx  = bp_pc[`BTB_IDX_W+1:2];
    assign upd_tag  = bp_pc[31:`BTB_IDX_W+2];

    // Only control transfers are allowed into the table
    assign upd_en = bp_update && (bp_opcode inside {BRANCH, JAL, JALR});

    // Combinational lookup
    assign predict_taken = valid_tab[look_idx] && (tag_tab[look_idx] == look_tag);
    assign target_addr   = tgt_tab[look_idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_tab <= '0;
        end else if (upd_en) begin
            valid_tab[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (upd_en) begin
            tag_tab[upd_idx] <= upd_tag;
            tgt_tab[upd_idx] <= bp_target;
        end
    end

    // Without RV32C every stored target is word aligned
    a_tgt_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        upd_en |=> (tgt_tab[$past(upd_idx)][1:0] == 2'b00))
        else $error("branch target written with bits 1:0 set");

endmodule

`default_nettype wire

//--- verilog/fetch_hazard_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch hazard control, purely combinational
// pc_en allows an advance, the fetch stage
// still moves the PC only when an item completes
// A misaligned PC never takes a prediction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fetch_hazard_unit
    import fetch_ctrl_pkg::*;
(
    input  logic     i_mem_busy,
    input  logic     redirect,
    input  logic     ex_stall,
    input  logic     mal_addr,
    input  logic     predict_taken,
    output logic     pc_en,
    output logic     if_ex_stall,
    output logic     if_ex_flush,
    output npc_src_t npc_sel
);

    // Execute back-pressure holds the fetch register as is
    assign if_ex_stall = ex_stall;

    // Bubble while waiting on memory, squash on redirect
    assign if_ex_flush = redirect || (i_mem_busy && !ex_stall);

    // Redirect always wins, else advance once memory is quiet
    assign pc_en = redirect || (!i_mem_busy && !ex_stall);

    always_comb begin
        if (redirect) begin
            npc_sel = REDIRECT;
        end else if (predict_taken && !mal_addr) begin
            npc_sel = PREDICT;
        end else begin
            npc_sel = SEQ;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage with one read in flight
// PC always names the oldest undelivered item
// A redirect drops the read in flight, the next
// read starts once the old one has drained
// fx payload is valid only with the fx_valid strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "fetch_consts.svh"

module fetch_stage
    import rv32_types_pkg::*, fetch_ctrl_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     pc_en,
    input  logic     if_ex_stall,
    input  logic     if_ex_flush,
    input  npc_src_t npc_sel,
    input  word_t    redirect_addr,
    input  logic     predict_taken,
    input  word_t    target_addr,
    output word_t    current_pc,
    output logic     ren,
    output word_t    addr,
    input  logic     busy,
    input  word_t    rdata,
    output logic     mal_addr,
    output logic     fx_valid,
    output word_t    fx_pc,
    output word_t    fx_pc4,
    output word_t    fx_instr,
    output logic     fx_mal_insn,
    output logic     fx_prediction
);
    word_t       pc;
    word_t       pc4;
    word_t       npc;
    word_t       bus_instr;
    word_t       held_instr;
    word_t       item_instr;
    imem_state_t rd_state;
    logic        cancel;
    logic        held_valid;
    logic        redirect_c;
    logic        rd_done;
    logic        rd_ok;
    logic        mal_done;
    logic        deliver;

    assign redirect_c = (npc_sel == REDIRECT);
    assign pc4        = pc + 32'd4;
    assign mal_addr   = (pc[1:0] != 2'b00);
    assign current_pc = pc;
    assign addr       = pc;

    always_comb begin
        case (npc_sel)
            REDIRECT: npc = redirect_addr;
            PREDICT:  npc = target_addr;
            default:  npc = pc4;
        endcase
    end

    // Bus byte order to instruction order
    generate
        if (`BUS_LITTLE_ENDIAN) begin : g_swap
            assign bus_instr = {rdata[7:0], rdata[15:8], rdata[23:16], rdata[31:24]};
        end else begin : g_pass
            assign bus_instr = rdata;
        end
    endgenerate

    // Read finishes in the first non-busy cycle after the request
    assign rd_done  = (rd_state == WAIT) && !busy;
    assign rd_ok    = rd_done && !cancel && !redirect_c;
    assign mal_done = mal_addr && (rd_state == IDLE);
    assign deliver  = !if_ex_stall && !redirect_c && (held_valid || rd_ok || mal_done);

    // Hold ren from request until the data cycle
    assign ren = (rd_state == WAIT)
              || (!held_valid && !mal_addr && !redirect_c);

    assign item_instr = held_valid ? held_instr : (mal_addr ? '0 : bus_instr);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= `RESET_PC;
        end else if (pc_en && (redirect_c || deliver)) begin
            pc <= npc;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_state <= IDLE;
            cancel   <= 1'b0;
        end else begin
            case (rd_state)
                IDLE:    if (ren) rd_state <= WAIT;
                WAIT:    if (!busy) rd_state <= IDLE;
                default: rd_state <= IDLE;
            endcase
            if (rd_done) begin
                cancel <= 1'b0;
            end else if (redirect_c && rd_state == WAIT) begin
                cancel <= 1'b1;
            end
        end
    end

    // Read finished under stall, keep it for later
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held_valid <= 1'b0;
        end else if (redirect_c || deliver) begin
            held_valid <= 1'b0;
        end else if (rd_ok && if_ex_stall) begin
            held_valid <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (rd_ok && if_ex_stall) begin
            held_instr <= bus_instr;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fx_valid      <= 1'b0;
            fx_pc         <= '0;
            fx_pc4        <= '0;
            fx_instr      <= '0;
            fx_mal_insn   <= 1'b0;
            fx_prediction <= 1'b0;
        end else if (deliver) begin
            fx_valid      <= 1'b1;
            fx_pc         <= pc;
            fx_pc4        <= pc4;
            fx_instr      <= item_instr;
            fx_mal_insn   <= mal_addr;
            fx_prediction <= predict_taken && !mal_addr;
        end else begin
            fx_valid <= 1'b0;
            if (if_ex_flush && !if_ex_stall) begin
                fx_pc         <= '0;
                fx_pc4        <= '0;
                fx_instr      <= '0;
                fx_mal_insn   <= 1'b0;
                fx_prediction <= 1'b0;
            end
        end
    end

    // Memory must answer a new request with busy on the next cycle
    a_busy_follows: assert property (@(posedge CLK) disable iff (!nRST)
        (rd_state == IDLE && ren) |=> busy)
        else $error("memory did not go busy after a read request");

endmodule

`default_nettype wire

//--- verilog/fetch_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction fetch front end, RV32I only
// redirect and bp_update are one-cycle strobes,
// ex_stall is a level held by execute
// No cycles are added at this level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fetch_subsystem
    import rv32_types_pkg::*, fetch_ctrl_pkg::*;
(
    input  logic    CLK,
    input  logic    nRST,
    input  logic    load_en,
    input  word_t   load_addr,
    input  word_t   load_data,
    input  logic    redirect,
    input  word_t   redirect_addr,
    input  logic    ex_stall,
    input  logic    bp_update,
    input  word_t   bp_pc,
    input  word_t   bp_target,
    input  opcode_t bp_opcode,
    output logic    fx_valid,
    output word_t   fx_pc,
    output word_t   fx_pc4,
    output word_t   fx_instr,
    output logic    fx_mal_insn,
    output logic    fx_prediction
);
    // Memory port
    logic     ren;
    word_t    addr;
    logic     busy;
    word_t    rdata;

    // Predictor lookup
    word_t    current_pc;
    logic     predict_taken;
    word_t    target_addr;

    // Hazard controls
    logic     pc_en;
    logic     if_ex_stall;
    logic     if_ex_flush;
    logic     mal_addr;
    npc_src_t npc_sel;

    imem_bus imem_bus_i (
        .CLK(CLK), .nRST(nRST),
        .ren(ren), .addr(addr),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .busy(busy), .rdata(rdata)
    );

    branch_predictor branch_predictor_i (
        .CLK(CLK), .nRST(nRST),
        .current_pc(current_pc), .predict_taken(predict_taken), .target_addr(target_addr),
        .bp_update(bp_update), .bp_pc(bp_pc), .bp_target(bp_target), .bp_opcode(bp_opcode)
    );

    fetch_hazard_unit fetch_hazard_unit_i (
        .i_mem_busy(busy), .redirect(redirect), .ex_stall(ex_stall),
        .mal_addr(mal_addr), .predict_taken(predict_taken),
        .pc_en(pc_en), .if_ex_stall(if_ex_stall), .if_ex_flush(if_ex_flush),
        .npc_sel(npc_sel)
    );

    fetch_stage fetch_stage_i (
        .CLK(CLK), .nRST(nRST),
        .pc_en(pc_en), .if_ex_stall(if_ex_stall), .if_ex_flush(if_ex_flush),
        .npc_sel(npc_sel), .redirect_addr(redirect_addr),
        .predict_taken(predict_taken), .target_addr(target_addr), .current_pc(current_pc),
        .ren(ren), .addr(addr), .busy(busy), .rdata(rdata), .mal_addr(mal_addr),
        .fx_valid(fx_valid), .fx_pc(fx_pc), .fx_pc4(fx_pc4), .fx_instr(fx_instr),
        .fx_mal_insn(fx_mal_insn), .fx_prediction(fx_prediction)
    );

endmodule

`default_nettype wire

//--- testbench/fetch_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the fetch front end
// Memory is preloaded under ex_stall, starting
// at the reset PC word, before fetch is released
// Predictor updates are sent only during a stall
// Each strobe wait gives up after 50 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb
    import rv32_types_pkg::*;
();
    logic    CLK;
    logic    nRST;
    logic    load_en;
    word_t   load_addr;
    word_t   load_data;
    logic    redirect;
    word_t   redirect_addr;
    logic    ex_stall;
    logic    bp_update;
    word_t   bp_pc;
    word_t   bp_target;
    opcode_t bp_opcode;
    logic    fx_valid;
    word_t   fx_pc;
    word_t   fx_pc4;
    word_t   fx_instr;
    logic    fx_mal_insn;
    logic    fx_prediction;

    // Reference copies of memory and predictor table
    word_t                  model_mem [`IMEM_WORDS];
    logic                   btb_valid [`BTB_ENTRIES];
    logic [29-`BTB_IDX_W:0] btb_tag   [`BTB_ENTRIES];
    word_t                  btb_tgt   [`BTB_ENTRIES];

    word_t exp_pc;
    word_t last_pc;
    word_t last_pc4;
    word_t last_instr;
    logic  last_mal;
    logic  last_pred;
    int    strobe_cnt;
    int    err_cnt;
    int    timeout_cnt;
    logic  timed_out;

    fetch_subsystem fetch_subsystem_i (
        .CLK(CLK), .nRST(nRST),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .redirect(redirect), .redirect_addr(redirect_addr), .ex_stall(ex_stall),
        .bp_update(bp_update), .bp_pc(bp_pc), .bp_target(bp_target), .bp_opcode(bp_opcode),
        .fx_valid(fx_valid), .fx_pc(fx_pc), .fx_pc4(fx_pc4), .fx_instr(fx_instr),
        .fx_mal_insn(fx_mal_insn), .fx_prediction(fx_prediction)
    );

    always #2 CLK = ~CLK;

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Expected fetch result for one PC, from the memory and table copies
    function automatic void expected_fetch(input word_t pc, output word_t instr,
                                           output logic mal, output logic pred,
                                           output word_t npc);
        word_t                 stored;
        logic [`BTB_IDX_W-1:0] bi;
        logic                  hit;
        stored = model_mem[pc[`IMEM_AW+1:2]];
        bi     = pc[`BTB_IDX_W+1:2];
        mal    = (pc[1:0] != 2'b00);
        hit    = btb_valid[bi] && (btb_tag[bi] == pc[31:`BTB_IDX_W+2]);
        pred   = hit && !mal;
        npc    = pred ? btb_tgt[bi] : pc + 32'd4;
        instr  = stored;
        if (`BUS_LITTLE_ENDIAN) begin
            for (int b = 0; b < 4; b++) begin
                instr[8*b +: 8] = stored[8*(3-b) +: 8];
            end
        end
        if (mal) begin
            instr = '0;
        end
    endfunction

    // Registered outputs are stable at the falling edge
    always @(negedge CLK) begin : compare_strobe
        word_t e_instr;
        logic  e_mal;
        logic  e_pred;
        word_t e_npc;
        if (nRST && fx_valid) begin
            expected_fetch(exp_pc, e_instr, e_mal, e_pred, e_npc);
            check_value("fx_pc", fx_pc, exp_pc);
            check_value("fx_pc4", fx_pc4, exp_pc + 32'd4);
            check_value("fx_instr", fx_instr, e_instr);
            check_value("fx_mal_insn", 32'(fx_mal_insn), 32'(e_mal));
            check_value("fx_prediction", 32'(fx_prediction), 32'(e_pred));
            last_pc    = fx_pc;
            last_pc4   = fx_pc4;
            last_instr = fx_instr;
            last_mal   = fx_mal_insn;
            last_pred  = fx_prediction;
            exp_pc     = e_npc;
            strobe_cnt++;
        end
    end

    function automatic word_t rand_aligned();
        return $urandom & 32'hFFFF_FFFC;
    endfunction

    task automatic wait_strobes(input int n);
        int target;
        int seen;
        int idle;
        @(posedge CLK);
        target = strobe_cnt + n;
        seen   = strobe_cnt;
        idle   = 0;
        while (strobe_cnt < target && !timed_out) begin
            @(posedge CLK);
            if (strobe_cnt != seen) begin
                seen = strobe_cnt;
                idle = 0;
            end else begin
                idle++;
                if (idle >= 50) begin
                    timed_out = 1'b1;
                    timeout_cnt++;
                    $display("Timeout at %0t: no fetch strobe for 50 cycles", $time);
                end
            end
        end
    endtask

    // Called on a falling edge, first word goes out at once
    task automatic preload_memory();
        imem_idx_t idx;
        word_t     data;
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            idx       = imem_idx_t'((`RESET_PC >> 2) + i);
            data      = $urandom;
            load_en   = 1'b1;
            load_addr = {22'd0, idx, 2'b00};
            load_data = data;
            model_mem[idx] = data;
            @(negedge CLK);
        end
        load_en = 1'b0;
    endtask

    task automatic do_redirect(input word_t target);
        @(negedge CLK);
        redirect      = 1'b1;
        redirect_addr = target;
        @(posedge CLK);
        exp_pc = target;
        @(negedge CLK);
        redirect = 1'b0;
    endtask

    task automatic update_predictor(input word_t pc, input word_t tgt, input opcode_t op);
        @(negedge CLK);
        bp_update = 1'b1;
        bp_pc     = pc;
        bp_target = tgt;
        bp_opcode = op;
        @(posedge CLK);
        // Only control transfers enter the table
        if (op == BRANCH || op == JAL || op == JALR) begin
            btb_valid[pc[`BTB_IDX_W+1:2]] = 1'b1;
            btb_tag[pc[`BTB_IDX_W+1:2]]   = pc[31:`BTB_IDX_W+2];
            btb_tgt[pc[`BTB_IDX_W+1:2]]   = tgt;
        end
        @(negedge CLK);
        bp_update = 1'b0;
    endtask

    // Train the entry for the PC waiting in fetch, then release it
    task automatic predictor_case(input opcode_t op);
        word_t pc;
        word_t tgt;
        logic  hit;
        @(negedge CLK);
        ex_stall = 1'b1;
        @(posedge CLK);
        pc  = exp_pc;
        tgt = rand_aligned();
        hit = (op == BRANCH);
        update_predictor(pc, tgt, op);
        @(negedge CLK);
        ex_stall = 1'b0;
        wait_strobes(1);
        check_value("fx_pc of trained PC", last_pc, pc);
        check_value("fx_prediction of trained PC", 32'(last_pred), 32'(hit));
        wait_strobes(1);
        check_value("fx_pc after trained PC", last_pc, hit ? tgt : pc + 32'd4);
    endtask

    task automatic stall_case(input int n);
        int base;
        @(negedge CLK);
        ex_stall = 1'b1;
        @(posedge CLK);
        base = strobe_cnt;
        repeat (n) @(posedge CLK);
        check_value("strobes during stall", 32'(strobe_cnt), 32'(base));
        @(negedge CLK);
        ex_stall = 1'b0;
        wait_strobes(4);
    endtask

    initial begin : run_tests
        word_t target;
        void'($urandom(32'h16487369));
        CLK           = 1'b0;
        nRST          = 1'b0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        redirect      = 1'b0;
        redirect_addr = '0;
        ex_stall      = 1'b1;
        bp_update     = 1'b0;
        bp_pc         = '0;
        bp_target     = '0;
        bp_opcode     = IMM;
        exp_pc        = `RESET_PC;
        last_pc       = '0;
        last_pc4      = '0;
        last_instr    = '0;
        last_mal      = 1'b0;
        last_pred     = 1'b0;
        strobe_cnt    = 0;
        err_cnt       = 0;
        timeout_cnt   = 0;
        timed_out     = 1'b0;
        for (int e = 0; e < `BTB_ENTRIES; e++) begin
            btb_valid[e] = 1'b0;
        end
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        preload_memory();
        @(posedge CLK);
        check_value("strobes during preload", 32'(strobe_cnt), 32'd0);
        @(negedge CLK);
        ex_stall = 1'b0;

        // Sequential fetch from the reset PC
        wait_strobes(1);
        check_value("first fx_pc", last_pc, `RESET_PC);
        check_value("first fx_pc4", last_pc4, `RESET_PC + 32'd4);
        wait_strobes(10);

        repeat (4) begin
            target = rand_aligned();
            do_redirect(target);
            wait_strobes(1);
            check_value("fx_pc after redirect", last_pc, target);
            wait_strobes(5);
        end

        // Non-branch update first, while the table is still empty
        predictor_case(LOAD);
        predictor_case(BRANCH);
        wait_strobes(4);

        repeat (3) begin
            stall_case(1 + int'($urandom % 12));
        end

        target = rand_aligned() | (32'd1 + $urandom % 3);
        do_redirect(target);
        wait_strobes(1);
        check_value("fx_mal_insn after odd redirect", 32'(last_mal), 32'd1);
        check_value("fx_instr after odd redirect", last_instr, 32'd0);
        wait_strobes(3);
        target = rand_aligned();
        do_redirect(target);
        wait_strobes(1);
        check_value("fx_mal_insn after aligned redirect", 32'(last_mal), 32'd0);
        wait_strobes(5);

        $display("Summary: %0d mismatches, %0d timeouts, %0d strobes checked",
                 err_cnt, timeout_cnt, strobe_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
verilog/rv32_types_pkg.sv
verilog/fetch_ctrl_pkg.sv
verilog/imem_bus.sv
verilog/branch_predictor.sv
verilog/fetch_hazard_unit.sv
verilog/fetch_stage.sv
verilog/fetch_subsystem.sv
testbench/fetch_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module fetch_tb \
    -f compile.f \
    --Mdir obj_dir -o fetch_sim

# The verdict comes from the simulation output, not its exit status
out=$(./obj_dir/fetch_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Done: no errors'; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
